// File: Bender.yml
package:
  name: bus_router

sources:
  - files:
      - hdl/router_pkg.sv
      - hdl/ahb_request_decoder.sv
      - hdl/target_arbiter.sv
      - hdl/router_control.sv
      - hdl/bus_router.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/bus_router_tb.sv

// File: build.f
hdl/router_pkg.sv
hdl/ahb_request_decoder.sv
hdl/target_arbiter.sv
hdl/router_control.sv
hdl/bus_router.sv
testbench/tb_clock_gen.sv
testbench/bus_router_tb.sv

// File: testbench/bus_router_tb.sv
module bus_router_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import router_pkg::*;

    localparam logic [31:0] SEED = 32'h5129_8c05;
    localparam int TIMEOUT = 20;

    logic clk, por, soft_reset, reset, spi_change;
    logic [31:0] spi_haddr, spi_hwdata, imem_haddr, imem_hwdata, dmem_haddr, dmem_hwdata;
    logic [2:0] spi_hsize, imem_hsize, dmem_hsize;
    logic [1:0] spi_htrans, imem_htrans, dmem_htrans;
    logic imem_hwrite, dmem_hwrite, imem_hready, dmem_hready;
    logic [31:0] imem_hrdata, dmem_hrdata, inst_write, data_write, reg_write;
    logic [31:0] inst_read, data_read, reg_read;
    logic [11:0] inst_addr, data_addr;
    logic [2:0] reg_addr;
    logic [3:0] inst_wben, data_wben, reg_wben;
    logic inst_rwn, data_rwn, reg_rwn, inst_en, data_en, reg_en;
    logic [31:0] lfsr;

    // Port fields packed as {index, wben, rwn, wdata}
    logic exp_run;
    logic [2:0] favor_dmem, exp_en, act_en;
    logic [2:0][48:0] exp_port, act_port;
    logic [32:0] imem_pipe, dmem_pipe;
    logic [32:0] imem_exp_rd, dmem_exp_rd;
    logic imem_req, dmem_req, collide, imem_exp_ready, dmem_exp_ready;
    int imem_tgt, dmem_tgt;

    tb_clock_gen clock_i (.clk(clk), .reset(por));

    assign reset = por || soft_reset;

    bus_router dut_i (.*);

    // Target models answer with the inverted word index
    assign inst_read = ~{20'd0, inst_addr};
    assign data_read = ~{20'd0, data_addr};
    assign reg_read = ~{29'd0, reg_addr};

    assign act_en = {reg_en, data_en, inst_en};
    assign act_port[0] = {inst_addr, inst_wben, inst_rwn, inst_write};
    assign act_port[1] = {data_addr, data_wben, data_rwn, data_write};
    assign act_port[2] = {9'd0, reg_addr, reg_wben, reg_rwn, reg_write};

    function automatic int target_of(input logic [31:0] addr);
        return addr[15] ? TGT_REG : (addr[14] ? TGT_DATA : TGT_INST);
    endfunction

    function automatic logic [3:0] lanes_of(input logic [31:0] addr, input logic [2:0] size);
        if (size == SIZE_BYTE) begin
            return 4'b0001 << addr[1:0];
        end
        if (size == SIZE_HALF) begin
            return (addr[1:0] == 2'b00) ? 4'b0011 : 4'b1100;
        end
        return 4'b1111;
    endfunction

    // Register block only sees three index bits
    function automatic logic [11:0] index_of(input logic [31:0] addr);
        return (target_of(addr) == TGT_REG) ? {9'd0, addr[4:2]} : addr[13:2];
    endfunction

    function automatic logic [48:0] port_of(input logic [31:0] addr, input logic [2:0] size,
                                            input logic write, input logic [31:0] wdata);
        return {index_of(addr), lanes_of(addr, size), !write, wdata};
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    assign imem_req = (imem_htrans == HTRANS_NONSEQ);
    assign dmem_req = (dmem_htrans == HTRANS_NONSEQ);
    assign imem_tgt = target_of(imem_haddr);
    assign dmem_tgt = target_of(dmem_haddr);
    assign collide = imem_req && dmem_req && (imem_tgt == dmem_tgt);
    assign imem_exp_ready = exp_run && !(collide && favor_dmem[imem_tgt]);
    assign dmem_exp_ready = exp_run && !(collide && !favor_dmem[dmem_tgt]);

    always_ff @(posedge clk) begin
        if (reset) begin
            exp_run <= 1'b0;
            favor_dmem <= 3'b111;
            exp_en <= '0;
        end else begin
            exp_en <= '0;
            if (spi_change) begin
                exp_run <= 1'b1;
            end
            if (!exp_run && spi_htrans == HTRANS_NONSEQ) begin
                exp_en[target_of(spi_haddr)] <= 1'b1;
                exp_port[target_of(spi_haddr)] <= port_of(spi_haddr, spi_hsize, 1'b1,
                                                          spi_hwdata);
            end
            if (exp_run && collide) begin
                favor_dmem[imem_tgt] <= !favor_dmem[imem_tgt];
            end
            if (imem_req && imem_exp_ready) begin
                exp_en[imem_tgt] <= 1'b1;
                exp_port[imem_tgt] <= port_of(imem_haddr, imem_hsize, imem_hwrite, imem_hwdata);
            end
            if (dmem_req && dmem_exp_ready) begin
                exp_en[dmem_tgt] <= 1'b1;
                exp_port[dmem_tgt] <= port_of(dmem_haddr, dmem_hsize, dmem_hwrite, dmem_hwdata);
            end
        end
    end

    // Read data lands two edges after acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            imem_pipe <= '0;
            dmem_pipe <= '0;
            imem_exp_rd <= '0;
            dmem_exp_rd <= '0;
        end else begin
            imem_pipe <= {imem_req && imem_exp_ready && !imem_hwrite,
                          ~{20'd0, index_of(imem_haddr)}};
            dmem_pipe <= {dmem_req && dmem_exp_ready && !dmem_hwrite,
                          ~{20'd0, index_of(dmem_haddr)}};
            if (imem_pipe[32]) begin
                imem_exp_rd <= imem_pipe;
            end
            if (dmem_pipe[32]) begin
                dmem_exp_rd <= dmem_pipe;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    for (genvar t = 0; t < 3; t++) begin : g_target
        a_en: assert property (@(posedge clk) disable iff (reset) act_en[t] == exp_en[t])
            else report_mismatch($sformatf("en_%0d", t), $sampled(exp_en[t]),
                                 $sampled(act_en[t]));
        a_port: assert property (@(posedge clk) disable iff (reset)
            act_en[t] |-> act_port[t] == exp_port[t])
            else report_mismatch($sformatf("port_%0d", t), $sampled(exp_port[t]),
                                 $sampled(act_port[t]));
    end

    a_imem_ready: assert property (@(posedge clk) disable iff (reset)
        imem_hready == imem_exp_ready)
        else report_mismatch("imem_hready", $sampled(imem_exp_ready), $sampled(imem_hready));
    a_dmem_ready: assert property (@(posedge clk) disable iff (reset)
        dmem_hready == dmem_exp_ready)
        else report_mismatch("dmem_hready", $sampled(dmem_exp_ready), $sampled(dmem_hready));

    a_imem_wait: assert property (@(posedge clk) disable iff (reset)
        exp_run && imem_req && !imem_hready |=> imem_hready)
        else fail_run("imem request lost two collisions in a row");
    a_dmem_wait: assert property (@(posedge clk) disable iff (reset)
        exp_run && dmem_req && !dmem_hready |=> dmem_hready)
        else fail_run("dmem request lost two collisions in a row");

    a_imem_rdata: assert property (@(posedge clk) disable iff (reset)
        imem_exp_rd[32] |-> imem_hrdata == imem_exp_rd[31:0])
        else report_mismatch("imem_hrdata", $sampled(imem_exp_rd[31:0]),
                             $sampled(imem_hrdata));
    a_dmem_rdata: assert property (@(posedge clk) disable iff (reset)
        dmem_exp_rd[32] |-> dmem_hrdata == dmem_exp_rd[31:0])
        else report_mismatch("dmem_hrdata", $sampled(dmem_exp_rd[31:0]),
                             $sampled(dmem_hrdata));

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (reset) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("reset was never released");
            end
        end
    endtask

    task automatic load_burst(input int count);
        for (int i = 0; i < count; i++) begin
            spi_haddr <= take_bits(32);
            spi_hsize <= 3'(take_bits(2));
            spi_hwdata <= take_bits(32);
            spi_htrans <= HTRANS_NONSEQ;
            @(posedge clk);
        end
        spi_htrans <= 2'b00;
    endtask

    // Held until hready and returns at the accepting edge
    task automatic core_access(input bit on_dmem, input int tgt, input bit read_only);
        logic [31:0] addr;
        logic [31:0] data;
        logic [2:0] size;
        logic write;
        logic ready;
        int waited;
        addr = take_bits(32);
        addr[15] = (tgt == TGT_REG);
        if (tgt != TGT_REG) begin
            addr[14] = (tgt == TGT_DATA);
        end
        size = 3'(take_bits(2));
        write = read_only ? 1'b0 : 1'(take_bits(1));
        data = take_bits(32);
        if (on_dmem) begin
            dmem_haddr <= addr;
            dmem_hsize <= size;
            dmem_hwrite <= write;
            dmem_hwdata <= data;
            dmem_htrans <= HTRANS_NONSEQ;
        end else begin
            imem_haddr <= addr;
            imem_hsize <= size;
            imem_hwrite <= write;
            imem_hwdata <= data;
            imem_htrans <= HTRANS_NONSEQ;
        end
        waited = 0;
        do begin
            @(negedge clk);
            ready = on_dmem ? dmem_hready : imem_hready;
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("core transfer was not accepted in time");
            end
        end while (!ready);
    endtask

    // Style 0 keeps the ports apart, 1 shares one target, 2 is random
    task automatic core_stream(input bit on_dmem, input int rounds, input int style,
                               input int shared_tgt);
        int tgt;
        for (int i = 0; i < rounds; i++) begin
            if (style == 1) begin
                tgt = shared_tgt;
            end else if (style == 2) begin
                tgt = take_bits(2) % 3;
            end else if (!on_dmem) begin
                tgt = TGT_INST;
            end else begin
                tgt = (i % 2 == 0) ? TGT_DATA : TGT_REG;
            end
            core_access(on_dmem, tgt, style == 1);
        end
        if (on_dmem) begin
            dmem_htrans <= 2'b00;
        end else begin
            imem_htrans <= 2'b00;
        end
    endtask

    task automatic core_traffic(input int rounds, input int style, input int shared_tgt);
        fork
            core_stream(1'b0, rounds, style, shared_tgt);
            core_stream(1'b1, rounds, style, shared_tgt);
        join
    endtask

    initial begin
        lfsr = SEED;
        soft_reset <= 1'b0;
        spi_change <= 1'b0;
        spi_haddr <= '0;
        spi_hwdata <= '0;
        spi_hsize <= SIZE_WORD;
        spi_htrans <= 2'b00;
        imem_haddr <= '0;
        imem_hwdata <= '0;
        imem_hsize <= SIZE_WORD;
        imem_hwrite <= 1'b0;
        imem_htrans <= 2'b00;
        dmem_haddr <= '0;
        dmem_hwdata <= '0;
        dmem_hsize <= SIZE_WORD;
        dmem_hwrite <= 1'b0;
        dmem_htrans <= 2'b00;
        wait_reset_release();

        // Core ports knock while the loader owns the bus
        imem_haddr <= take_bits(32);
        imem_htrans <= HTRANS_NONSEQ;
        dmem_haddr <= take_bits(32);
        dmem_htrans <= HTRANS_NONSEQ;
        load_burst(24);
        imem_htrans <= 2'b00;
        dmem_htrans <= 2'b00;

        spi_change <= 1'b1;
        @(posedge clk);
        spi_change <= 1'b0;
        core_traffic(16, 0, 0);
        for (int t = 0; t < 3; t++) begin
            core_traffic(8, 1, t);
        end
        core_traffic(40, 2, 0);

        repeat (3) @(posedge clk);
        soft_reset <= 1'b1;
        repeat (2) @(posedge clk);
        soft_reset <= 1'b0;
        wait_reset_release();
        load_burst(8);
        repeat (4) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 10ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Held over two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: hdl/bus_router.sv
module bus_router (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              spi_change,
    input  logic [router_pkg::ADDR_W-1:0]     spi_haddr,
    input  logic [router_pkg::DATA_W-1:0]     spi_hwdata,
    input  logic [2:0]                        spi_hsize,
    input  logic [1:0]                        spi_htrans,
    input  logic [router_pkg::ADDR_W-1:0]     imem_haddr,
    input  logic [router_pkg::DATA_W-1:0]     imem_hwdata,
    input  logic [2:0]                        imem_hsize,
    input  logic                              imem_hwrite,
    input  logic [1:0]                        imem_htrans,
    output logic                              imem_hready,
    output logic [router_pkg::DATA_W-1:0]     imem_hrdata,
    input  logic [router_pkg::ADDR_W-1:0]     dmem_haddr,
    input  logic [router_pkg::DATA_W-1:0]     dmem_hwdata,
    input  logic [2:0]                        dmem_hsize,
    input  logic                              dmem_hwrite,
    input  logic [1:0]                        dmem_htrans,
    output logic                              dmem_hready,
    output logic [router_pkg::DATA_W-1:0]     dmem_hrdata,
    output logic [router_pkg::WORD_IDX_W-1:0] inst_addr,
    output logic [router_pkg::DATA_W-1:0]     inst_write,
    output logic [router_pkg::WBEN_W-1:0]     inst_wben,
    output logic                              inst_rwn,
    output logic                              inst_en,
    input  logic [router_pkg::DATA_W-1:0]     inst_read,
    output logic [router_pkg::WORD_IDX_W-1:0] data_addr,
    output logic [router_pkg::DATA_W-1:0]     data_write,
    output logic [router_pkg::WBEN_W-1:0]     data_wben,
    output logic                              data_rwn,
    output logic                              data_en,
    input  logic [router_pkg::DATA_W-1:0]     data_read,
    output logic [router_pkg::REG_IDX_W-1:0]  reg_addr,
    output logic [router_pkg::DATA_W-1:0]     reg_write,
    output logic [router_pkg::WBEN_W-1:0]     reg_wben,
    output logic                              reg_rwn,
    output logic                              reg_en,
    input  logic [router_pkg::DATA_W-1:0]     reg_read
);
    import router_pkg::*;

    logic spi_valid, imem_valid, dmem_valid;
    target_e spi_target, imem_target, dmem_target;
    logic [WORD_IDX_W-1:0] spi_word_idx, imem_word_idx, dmem_word_idx;
    logic [WBEN_W-1:0] spi_wben, imem_wben, dmem_wben;
    logic spi_write, imem_write, dmem_write;
    logic [DATA_W-1:0] spi_wdata, imem_wdata, dmem_wdata;
    logic inst_grant_spi, inst_grant_imem, inst_grant_dmem;
    logic data_grant_spi, data_grant_imem, data_grant_dmem;
    logic reg_grant_spi, reg_grant_imem, reg_grant_dmem;
    logic [WORD_IDX_W-1:0] reg_word_idx;
    mode_e mode;

    assign reg_addr = reg_word_idx[REG_IDX_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Requester decoders
    ////////////////////////////////////////////////////////////////////////////

    // Loader transfers are always writes
    ahb_request_decoder spi_dec_i (
        .haddr(spi_haddr), .hsize(spi_hsize), .htrans(spi_htrans), .hwrite(1'b1),
        .hwdata(spi_hwdata), .valid(spi_valid), .target(spi_target),
        .word_idx(spi_word_idx), .wben(spi_wben), .write(spi_write), .wdata(spi_wdata)
    );

    ahb_request_decoder imem_dec_i (
        .haddr(imem_haddr), .hsize(imem_hsize), .htrans(imem_htrans), .hwrite(imem_hwrite),
        .hwdata(imem_hwdata), .valid(imem_valid), .target(imem_target),
        .word_idx(imem_word_idx), .wben(imem_wben), .write(imem_write), .wdata(imem_wdata)
    );

    ahb_request_decoder dmem_dec_i (
        .haddr(dmem_haddr), .hsize(dmem_hsize), .htrans(dmem_htrans), .hwrite(dmem_hwrite),
        .hwdata(dmem_hwdata), .valid(dmem_valid), .target(dmem_target),
        .word_idx(dmem_word_idx), .wben(dmem_wben), .write(dmem_write), .wdata(dmem_wdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Target arbiters
    ////////////////////////////////////////////////////////////////////////////

    target_arbiter inst_arb_i (
        .clk(clk), .reset(reset), .mode(mode), .my_target(TGT_INST),
        .spi_valid(spi_valid), .spi_target(spi_target), .spi_word_idx(spi_word_idx),
        .spi_wben(spi_wben), .spi_write(spi_write), .spi_wdata(spi_wdata),
        .imem_valid(imem_valid), .imem_target(imem_target), .imem_word_idx(imem_word_idx),
        .imem_wben(imem_wben), .imem_write(imem_write), .imem_wdata(imem_wdata),
        .dmem_valid(dmem_valid), .dmem_target(dmem_target), .dmem_word_idx(dmem_word_idx),
        .dmem_wben(dmem_wben), .dmem_write(dmem_write), .dmem_wdata(dmem_wdata),
        .grant_spi(inst_grant_spi), .grant_imem(inst_grant_imem),
        .grant_dmem(inst_grant_dmem), .addr(inst_addr), .wdata(inst_write),
        .wben(inst_wben), .rwn(inst_rwn), .en(inst_en)
    );

    target_arbiter data_arb_i (
        .clk(clk), .reset(reset), .mode(mode), .my_target(TGT_DATA),
        .spi_valid(spi_valid), .spi_target(spi_target), .spi_word_idx(spi_word_idx),
        .spi_wben(spi_wben), .spi_write(spi_write), .spi_wdata(spi_wdata),
        .imem_valid(imem_valid), .imem_target(imem_target), .imem_word_idx(imem_word_idx),
        .imem_wben(imem_wben), .imem_write(imem_write), .imem_wdata(imem_wdata),
        .dmem_valid(dmem_valid), .dmem_target(dmem_target), .dmem_word_idx(dmem_word_idx),
        .dmem_wben(dmem_wben), .dmem_write(dmem_write), .dmem_wdata(dmem_wdata),
        .grant_spi(data_grant_spi), .grant_imem(data_grant_imem),
        .grant_dmem(data_grant_dmem), .addr(data_addr), .wdata(data_write),
        .wben(data_wben), .rwn(data_rwn), .en(data_en)
    );

    target_arbiter reg_arb_i (
        .clk(clk), .reset(reset), .mode(mode), .my_target(TGT_REG),
        .spi_valid(spi_valid), .spi_target(spi_target), .spi_word_idx(spi_word_idx),
        .spi_wben(spi_wben), .spi_write(spi_write), .spi_wdata(spi_wdata),
        .imem_valid(imem_valid), .imem_target(imem_target), .imem_word_idx(imem_word_idx),
        .imem_wben(imem_wben), .imem_write(imem_write), .imem_wdata(imem_wdata),
        .dmem_valid(dmem_valid), .dmem_target(dmem_target), .dmem_word_idx(dmem_word_idx),
        .dmem_wben(dmem_wben), .dmem_write(dmem_write), .dmem_wdata(dmem_wdata),
        .grant_spi(reg_grant_spi), .grant_imem(reg_grant_imem),
        .grant_dmem(reg_grant_dmem), .addr(reg_word_idx), .wdata(reg_write),
        .wben(reg_wben), .rwn(reg_rwn), .en(reg_en)
    );

    router_control control_i (
        .clk(clk), .reset(reset), .spi_change(spi_change),
        .inst_grant_spi(inst_grant_spi), .inst_grant_imem(inst_grant_imem),
        .inst_grant_dmem(inst_grant_dmem), .data_grant_spi(data_grant_spi),
        .data_grant_imem(data_grant_imem), .data_grant_dmem(data_grant_dmem),
        .reg_grant_spi(reg_grant_spi), .reg_grant_imem(reg_grant_imem),
        .reg_grant_dmem(reg_grant_dmem), .imem_valid(imem_valid),
        .imem_target(imem_target), .dmem_valid(dmem_valid), .dmem_target(dmem_target),
        .inst_read(inst_read), .data_read(data_read), .reg_read(reg_read),
        .inst_en(inst_en), .data_en(data_en), .reg_en(reg_en),
        .inst_rwn(inst_rwn), .data_rwn(data_rwn), .reg_rwn(reg_rwn),
        .mode(mode), .imem_hready(imem_hready), .dmem_hready(dmem_hready),
        .imem_hrdata(imem_hrdata), .dmem_hrdata(dmem_hrdata)
    );

endmodule

// File: hdl/router_control.sv
module router_control (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          spi_change,
    input  logic                          inst_grant_spi,
    input  logic                          inst_grant_imem,
    input  logic                          inst_grant_dmem,
    input  logic                          data_grant_spi,
    input  logic                          data_grant_imem,
    input  logic                          data_grant_dmem,
    input  logic                          reg_grant_spi,
    input  logic                          reg_grant_imem,
    input  logic                          reg_grant_dmem,
    input  logic                          imem_valid,
    input  router_pkg::target_e           imem_target,
    input  logic                          dmem_valid,
    input  router_pkg::target_e           dmem_target,
    input  logic [router_pkg::DATA_W-1:0] inst_read,
    input  logic [router_pkg::DATA_W-1:0] data_read,
    input  logic [router_pkg::DATA_W-1:0] reg_read,
    input  logic                          inst_en,
    input  logic                          data_en,
    input  logic                          reg_en,
    input  logic                          inst_rwn,
    input  logic                          data_rwn,
    input  logic                          reg_rwn,
    output router_pkg::mode_e             mode,
    output logic                          imem_hready,
    output logic                          dmem_hready,
    output logic [router_pkg::DATA_W-1:0] imem_hrdata,
    output logic [router_pkg::DATA_W-1:0] dmem_hrdata
);
    import router_pkg::*;

    logic imem_granted;
    logic dmem_granted;
    req_id_e inst_owner;
    req_id_e data_owner;
    req_id_e reg_owner;

    function automatic req_id_e next_owner(input logic g_spi, input logic g_imem,
                                           input logic g_dmem, input req_id_e cur);
        req_id_e id;
        id = cur;
        if (g_spi) begin
            id = REQ_SPI;
        end else if (g_imem) begin
            id = REQ_IMEM;
        end else if (g_dmem) begin
            id = REQ_DMEM;
        end
        return id;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= MODE_LOAD;
        end else if (mode == MODE_LOAD && spi_change) begin
            mode <= MODE_RUN;
        end
    end

    // Only the addressed arbiter can grant a port
    always_comb begin
        case (imem_target)
            TGT_INST: imem_granted = inst_grant_imem;
            TGT_DATA: imem_granted = data_grant_imem;
            default: imem_granted = reg_grant_imem;
        endcase
        case (dmem_target)
            TGT_INST: dmem_granted = inst_grant_dmem;
            TGT_DATA: dmem_granted = data_grant_dmem;
            default: dmem_granted = reg_grant_dmem;
        endcase
    end

    assign imem_hready = (mode == MODE_RUN) && !(imem_valid && !imem_granted);
    assign dmem_hready = (mode == MODE_RUN) && !(dmem_valid && !dmem_granted);

    ////////////////////////////////////////////////////////////////////////////
    // Read return
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_owner <= REQ_SPI;
            data_owner <= REQ_SPI;
            reg_owner <= REQ_SPI;
        end else begin
            inst_owner <= next_owner(inst_grant_spi, inst_grant_imem, inst_grant_dmem, inst_owner);
            data_owner <= next_owner(data_grant_spi, data_grant_imem, data_grant_dmem, data_owner);
            reg_owner <= next_owner(reg_grant_spi, reg_grant_imem, reg_grant_dmem, reg_owner);
        end
    end

    // A port owns at most one en cycle at a time
    always_ff @(posedge clk) begin
        if (inst_en && inst_rwn && inst_owner == REQ_IMEM) imem_hrdata <= inst_read;
        if (data_en && data_rwn && data_owner == REQ_IMEM) imem_hrdata <= data_read;
        if (reg_en && reg_rwn && reg_owner == REQ_IMEM) imem_hrdata <= reg_read;
        if (inst_en && inst_rwn && inst_owner == REQ_DMEM) dmem_hrdata <= inst_read;
        if (data_en && data_rwn && data_owner == REQ_DMEM) dmem_hrdata <= data_read;
        if (reg_en && reg_rwn && reg_owner == REQ_DMEM) dmem_hrdata <= reg_read;
    end

    a_no_ready_in_load: assert property (@(posedge clk) disable iff (reset)
        mode == MODE_LOAD |-> !imem_hready && !dmem_hready);

endmodule

// File: hdl/target_arbiter.sv
module target_arbiter (
    input  logic                              clk,
    input  logic                              reset,
    input  router_pkg::mode_e                 mode,
    input  router_pkg::target_e               my_target,
    input  logic                              spi_valid,
    input  router_pkg::target_e               spi_target,
    input  logic [router_pkg::WORD_IDX_W-1:0] spi_word_idx,
    input  logic [router_pkg::WBEN_W-1:0]     spi_wben,
    input  logic                              spi_write,
    input  logic [router_pkg::DATA_W-1:0]     spi_wdata,
    input  logic                              imem_valid,
    input  router_pkg::target_e               imem_target,
    input  logic [router_pkg::WORD_IDX_W-1:0] imem_word_idx,
    input  logic [router_pkg::WBEN_W-1:0]     imem_wben,
    input  logic                              imem_write,
    input  logic [router_pkg::DATA_W-1:0]     imem_wdata,
    input  logic                              dmem_valid,
    input  router_pkg::target_e               dmem_target,
    input  logic [router_pkg::WORD_IDX_W-1:0] dmem_word_idx,
    input  logic [router_pkg::WBEN_W-1:0]     dmem_wben,
    input  logic                              dmem_write,
    input  logic [router_pkg::DATA_W-1:0]     dmem_wdata,
    output logic                              grant_spi,
    output logic                              grant_imem,
    output logic                              grant_dmem,
    output logic [router_pkg::WORD_IDX_W-1:0] addr,
    output logic [router_pkg::DATA_W-1:0]     wdata,
    output logic [router_pkg::WBEN_W-1:0]     wben,
    output logic                              rwn,
    output logic                              en
);
    import router_pkg::*;

    logic spi_hit;
    logic imem_hit;
    logic dmem_hit;
    logic collision;
    req_id_e favor;

    assign spi_hit = spi_valid && (spi_target == my_target);
    assign imem_hit = imem_valid && (imem_target == my_target);
    assign dmem_hit = dmem_valid && (dmem_target == my_target);
    assign collision = (mode == MODE_RUN) && imem_hit && dmem_hit;

    ////////////////////////////////////////////////////////////////////////////
    // Grants
    ////////////////////////////////////////////////////////////////////////////

    assign grant_spi = (mode == MODE_LOAD) && spi_hit;
    assign grant_imem = (mode == MODE_RUN) && imem_hit && (!dmem_hit || favor == REQ_IMEM);
    assign grant_dmem = (mode == MODE_RUN) && dmem_hit && (!imem_hit || favor == REQ_DMEM);

    // Loser of a collision wins the next one
    always_ff @(posedge clk) begin
        if (reset) begin
            favor <= REQ_DMEM;
        end else if (collision) begin
            favor <= (favor == REQ_IMEM) ? REQ_DMEM : REQ_IMEM;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Target port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            en <= 1'b0;
        end else begin
            en <= grant_spi || grant_imem || grant_dmem;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_spi) begin
            addr <= spi_word_idx;
            wdata <= spi_wdata;
            wben <= spi_wben;
            rwn <= !spi_write;
        end else if (grant_imem) begin
            addr <= imem_word_idx;
            wdata <= imem_wdata;
            wben <= imem_wben;
            rwn <= !imem_write;
        end else if (grant_dmem) begin
            addr <= dmem_word_idx;
            wdata <= dmem_wdata;
            wben <= dmem_wben;
            rwn <= !dmem_write;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({grant_spi, grant_imem, grant_dmem}));

    a_no_core_in_load: assert property (@(posedge clk) disable iff (reset)
        mode == MODE_LOAD |-> !grant_imem && !grant_dmem);

endmodule

// File: hdl/ahb_request_decoder.sv
module ahb_request_decoder (
    input  logic [router_pkg::ADDR_W-1:0]     haddr,
    input  logic [2:0]                        hsize,
    input  logic [1:0]                        htrans,
    input  logic                              hwrite,
    input  logic [router_pkg::DATA_W-1:0]     hwdata,
    output logic                              valid,
    output router_pkg::target_e               target,
    output logic [router_pkg::WORD_IDX_W-1:0] word_idx,
    output logic [router_pkg::WBEN_W-1:0]     wben,
    output logic                              write,
    output logic [router_pkg::DATA_W-1:0]     wdata
);
    import router_pkg::*;

    logic [1:0] byte_off;

    assign byte_off = haddr[1:0];

    assign valid = (htrans == HTRANS_NONSEQ);
    assign word_idx = haddr[WORD_IDX_W+1:2];
    assign write = hwrite;
    assign wdata = hwdata;

    // Register block sits above both RAMs
    always_comb begin
        if (haddr[REG_SEL_BIT]) begin
            target = TGT_REG;
        end else if (haddr[DMEM_SEL_BIT]) begin
            target = TGT_DATA;
        end else begin
            target = TGT_INST;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte lanes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (hsize)
            SIZE_BYTE: begin
                case (byte_off)
                    2'b00: wben = 4'b0001;
                    2'b01: wben = 4'b0010;
                    2'b10: wben = 4'b0100;
                    default: wben = 4'b1000;
                endcase
            end
            SIZE_HALF: begin
                // Misaligned halves fall to the upper pair
                if (byte_off == 2'b00) begin
                    wben = 4'b0011;
                end else begin
                    wben = 4'b1100;
                end
            end
            SIZE_WORD: begin
                wben = 4'b1111;
            end
            default: begin
                wben = 4'b1111;
            end
        endcase
    end

endmodule

// File: hdl/router_pkg.sv
package router_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int WBEN_W = 4;

    // RAM word index comes from address bits 13:2
    localparam int WORD_IDX_W = 12;
    localparam int REG_IDX_W = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Address map and AHB codes
    ////////////////////////////////////////////////////////////////////////////

    // Bit 15 wins over bit 14
    localparam int REG_SEL_BIT = 15;
    localparam int DMEM_SEL_BIT = 14;

    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    localparam logic [2:0] SIZE_BYTE = 3'd0;
    localparam logic [2:0] SIZE_HALF = 3'd1;
    localparam logic [2:0] SIZE_WORD = 3'd2;

    ////////////////////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        TGT_INST,
        TGT_DATA,
        TGT_REG
    } target_e;

    // Loader only until spi_change
    typedef enum logic {
        MODE_LOAD,
        MODE_RUN
    } mode_e;

    typedef enum logic [1:0] {
        REQ_SPI,
        REQ_IMEM,
        REQ_DMEM
    } req_id_e;

endpackage
